//--- Bender.yml
package:
  name: io_block

sources:
  - include_dirs:
      - logic
    files:
      - logic/io_pkg.sv
      - logic/uart_pkg.sv
      - logic/axil_io_slave.sv
      - logic/io_regs.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/io_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/io_chk.sv
      - bench/io_tb.sv

//--- bench/io_chk.sv
`timescale 1ns/1ps

module io_chk (
    input  logic               clk,
    input  logic               rst,
    input  logic               rvalid,
    input  logic               rready,
    input  io_pkg::word_t      rdata,
    input  io_pkg::resp_t      rresp,
    input  logic               bvalid,
    input  logic               bready,
    input  io_pkg::resp_t      bresp,
    input  logic               reg_rd_en,
    input  logic               reg_wr_en,
    input  logic               tx_valid,
    input  logic               tx_ready,
    input  logic               rx_valid,
    input  logic               rx_ready,
    input  io_pkg::event_cnt_t inst_cnt
);

    // read by the testbench for its final count
    int unsigned fails = 0;

    // **************************************************
    // bus channels
    // **************************************************

    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        fails++;
        $error("rvalid or rdata changed before rready");
    end

    bresp_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        fails++;
        $error("bvalid or bresp changed before bready");
    end

    resp_okay: assert property (@(posedge clk) disable iff (rst)
        bresp == io_pkg::resp_okay && rresp == io_pkg::resp_okay)
    else begin
        fails++;
        $error("response other than OKAY");
    end

    // **************************************************
    // register block
    // **************************************************

    one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(reg_rd_en && reg_wr_en))
    else begin
        fails++;
        $error("register read and write strobes high together");
    end

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid)
    else begin
        fails++;
        $error("tx_valid dropped before the transmitter took the byte");
    end

    rx_hold: assert property (@(posedge clk) disable iff (rst)
        rx_valid && !rx_ready |=> rx_valid)
    else begin
        fails++;
        $error("rx_valid dropped before the buffer took the byte");
    end

    // a clear brings the count back to zero, anything else adds at most two
    inst_step: assert property (@(posedge clk) disable iff (rst)
        ##1 (inst_cnt == '0) || (inst_cnt - $past(inst_cnt) <= 2))
    else begin
        fails++;
        $error("instruction count grew by more than two in one cycle");
    end

endmodule

bind io_top io_chk io_chk_inst (
    .clk       (clk),
    .rst       (rst),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .reg_rd_en (reg_rd_en),
    .reg_wr_en (reg_wr_en),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .inst_cnt  (io_regs_inst.inst_cnt)
);

//--- bench/io_tb.sv
`timescale 1ns/1ps

`include "io_params.svh"

module io_tb;

    localparam int unsigned clks_per_bit = 8;

    logic          clk;
    logic          rst;
    io_pkg::word_t awaddr;
    logic          awvalid;
    logic          awready;
    io_pkg::word_t wdata;
    logic          wvalid;
    logic          wready;
    io_pkg::resp_t bresp;
    logic          bvalid;
    logic          bready;
    io_pkg::word_t araddr;
    logic          arvalid;
    logic          arready;
    io_pkg::word_t rdata;
    io_pkg::resp_t rresp;
    logic          rvalid;
    logic          rready;
    io_pkg::word_t inst;
    io_pkg::word_t fp_inst;
    logic          br_inst;
    logic          br_suc;
    logic          serial_in;
    logic          serial_out;

    logic [31:0]   lfsr_state;
    logic          throttle;
    int unsigned   errors;
    int unsigned   checks;
    int unsigned   tests;
    int unsigned   errors_at_start;

    io_top #(.clks_per_bit(clks_per_bit)) io_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // taps 32, 22, 2 and 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic check_range(input string name, input io_pkg::word_t got,
                               input io_pkg::word_t lo, input io_pkg::word_t hi);
        checks++;
        assert (got >= lo && got <= hi) else begin
            errors++;
            if (lo == hi) begin
                $display("ERROR %s got %h expected %h", name, got, lo);
            end else begin
                $display("ERROR %s got %h expected %h to %h", name, got, lo, hi);
            end
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    // **************************************************
    // bus transfers
    // **************************************************

    task automatic bus_write(input io_pkg::reg_addr_t addr, input io_pkg::word_t data);
        int unsigned n;
        @(posedge clk);
        awaddr <= io_pkg::word_t'(addr);
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(awready && wready) && n < 50);
        if (!(awready && wready)) begin
            report_timeout("awready and wready");
        end
        n = 0;
        do begin
            @(posedge clk);
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= throttle ? lfsr_bit() : 1'b1;
            @(negedge clk);
            n++;
        end while (!(bvalid && bready) && n < 50);
        if (!(bvalid && bready)) begin
            report_timeout("bvalid");
        end
        check_range("bresp", bresp, io_pkg::resp_okay, io_pkg::resp_okay);
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic bus_read(input io_pkg::reg_addr_t addr, output io_pkg::word_t data);
        int unsigned n;
        @(posedge clk);
        araddr <= io_pkg::word_t'(addr);
        arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!arready && n < 50);
        if (!arready) begin
            report_timeout("arready");
        end
        n = 0;
        do begin
            @(posedge clk);
            arvalid <= 1'b0;
            rready <= throttle ? lfsr_bit() : 1'b1;
            @(negedge clk);
            n++;
        end while (!(rvalid && rready) && n < 50);
        if (!(rvalid && rready)) begin
            report_timeout("rvalid");
        end
        data = rdata;
        check_range("rresp", rresp, io_pkg::resp_okay, io_pkg::resp_okay);
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // polls CTRL until one of the bits in mask is set
    task automatic wait_ctrl(input io_pkg::word_t mask, input string what);
        io_pkg::word_t v;
        int unsigned   n;
        n = 0;
        do begin
            bus_read(`IO_ADDR_UART_CTRL, v);
            n++;
        end while ((v & mask) == 0 && n < 40);
        if ((v & mask) == 0) begin
            report_timeout(what);
        end
    endtask

    // **************************************************
    // serial lines
    // **************************************************

    task automatic send_serial(input uart_pkg::byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            serial_in <= frame[i];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
    endtask

    task automatic monitor_serial(output uart_pkg::byte_t value);
        int unsigned n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (serial_out && n < 200);
        if (serial_out) begin
            report_timeout("start bit on serial_out");
        end
        // move to the middle of the start bit
        repeat (clks_per_bit / 2 - 1) @(negedge clk);
        check_range("serial_out start bit", serial_out, 0, 0);
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            value[i] = serial_out;
        end
        repeat (clks_per_bit) @(negedge clk);
        check_range("serial_out stop bit", serial_out, 1, 1);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // **************************************************
    // tests
    // **************************************************

    initial begin
        io_pkg::word_t   value;
        io_pkg::word_t   first;
        uart_pkg::byte_t seen;
        int unsigned     inst_sum;
        int unsigned     br_sum;
        int unsigned     suc_sum;
        logic            a;
        logic            b;
        logic            c;
        logic            d;
        lfsr_state = 32'hd9fd;
        throttle = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        errors_at_start = 0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        inst = `IO_NOP;
        fp_inst = `IO_NOP;
        br_inst = 1'b0;
        br_suc = 1'b0;
        serial_in = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        bus_read(`IO_ADDR_UART_CTRL, value);
        check_range("ctrl", value, 1, 1);
        bus_read(8'h20, value);
        check_range("rdata at 0x20", value, 0, 0);
        bus_read(8'hfc, value);
        check_range("rdata at 0xfc", value, 0, 0);
        // write and read requested together so the slave has to arbitrate
        fork
            bus_write(8'h20, 32'h1234_5678);
            bus_read(`IO_ADDR_UART_CTRL, value);
        join
        check_range("ctrl", value, 1, 1);
        finish_test("reset state and unmapped reads");

        bus_write(`IO_ADDR_RST_CNT, '0);
        inst_sum = 0;
        br_sum = 0;
        suc_sum = 0;
        repeat (64) begin
            @(posedge clk);
            a = lfsr_bit();
            b = lfsr_bit();
            c = lfsr_bit();
            d = lfsr_bit();
            inst <= a ? 32'h0010_0093 : `IO_NOP;
            fp_inst <= b ? 32'h0020_f053 : `IO_NOP;
            br_inst <= c;
            br_suc <= c & d;
            inst_sum += int'(a) + int'(b);
            br_sum += int'(c);
            suc_sum += int'(c & d);
        end
        @(posedge clk);
        inst <= `IO_NOP;
        fp_inst <= `IO_NOP;
        br_inst <= 1'b0;
        br_suc <= 1'b0;
        bus_read(`IO_ADDR_INST_CNT, value);
        check_range("inst_cnt", value, inst_sum, inst_sum);
        bus_read(`IO_ADDR_BR_INST_CNT, value);
        check_range("br_inst_cnt", value, br_sum, br_sum);
        bus_read(`IO_ADDR_BR_SUC_CNT, value);
        check_range("br_suc_cnt", value, suc_sum, suc_sum);
        finish_test("event counters");

        throttle = 1'b1;
        repeat (3) begin
            bus_read(`IO_ADDR_UART_CTRL, value);
            check_range("ctrl", value, 1, 1);
            bus_read(`IO_ADDR_INST_CNT, value);
            check_range("inst_cnt", value, inst_sum, inst_sum);
            bus_read(`IO_ADDR_BR_INST_CNT, value);
            check_range("br_inst_cnt", value, br_sum, br_sum);
            bus_read(`IO_ADDR_BR_SUC_CNT, value);
            check_range("br_suc_cnt", value, suc_sum, suc_sum);
            bus_write(8'h24, 32'hffff_ffff);
            bus_read(8'h24, value);
            check_range("rdata at 0x24", value, 0, 0);
        end
        throttle = 1'b0;
        finish_test("reads under rready back-pressure");

        bus_read(`IO_ADDR_CYCLE_CNT, first);
        repeat (20) @(posedge clk);
        bus_read(`IO_ADDR_CYCLE_CNT, value);
        check_range("cycle_cnt step", value - first, 20, 32'hffff_ffff);
        bus_write(`IO_ADDR_RST_CNT, '0);
        bus_read(`IO_ADDR_CYCLE_CNT, value);
        check_range("cycle_cnt after clear", value, 0, 16);
        finish_test("cycle counter");

        fork
            monitor_serial(seen);
            begin
                bus_write(`IO_ADDR_UART_TDATA, 32'h0000_00a5);
                bus_read(`IO_ADDR_UART_CTRL, value);
                // this byte waits until the frame on the line is done
                bus_write(`IO_ADDR_UART_TDATA, 32'h0000_005a);
            end
        join
        check_range("ctrl during frame", value, 0, 0);
        check_range("serial_out byte", seen, 8'ha5, 8'ha5);
        monitor_serial(seen);
        check_range("serial_out second byte", seen, 8'h5a, 8'h5a);
        wait_ctrl(32'h1, "transmitter idle");
        bus_read(`IO_ADDR_UART_CTRL, value);
        check_range("ctrl after frame", value, 1, 1);
        finish_test("uart transmit");

        // the second byte waits in the receiver until the buffer is read
        send_serial(8'h3c);
        send_serial(8'hc3);
        wait_ctrl(32'h2, "receive buffer full");
        bus_read(`IO_ADDR_UART_CTRL, value);
        check_range("ctrl with byte waiting", value, 3, 3);
        bus_read(`IO_ADDR_UART_RDATA, value);
        check_range("uart rdata", value, 8'h3c, 8'h3c);
        bus_read(`IO_ADDR_UART_CTRL, value);
        check_range("ctrl with second byte", value, 3, 3);
        bus_read(`IO_ADDR_UART_RDATA, value);
        check_range("uart rdata", value, 8'hc3, 8'hc3);
        bus_read(`IO_ADDR_UART_CTRL, value);
        check_range("ctrl after rdata read", value, 1, 1);
        finish_test("uart receive");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, io_top_inst.io_chk_inst.fails);
        if (errors == 0 && io_top_inst.io_chk_inst.fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- logic/axil_io_slave.sv
`timescale 1ns/1ps

module axil_io_slave (
    input  logic              clk,
    input  logic              rst,

    input  io_pkg::word_t     awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  io_pkg::word_t     wdata,
    input  logic              wvalid,
    output logic              wready,
    output io_pkg::resp_t     bresp,
    output logic              bvalid,
    input  logic              bready,
    input  io_pkg::word_t     araddr,
    input  logic              arvalid,
    output logic              arready,
    output io_pkg::word_t     rdata,
    output io_pkg::resp_t     rresp,
    output logic              rvalid,
    input  logic              rready,

    output logic              reg_rd_en,
    output logic              reg_wr_en,
    output io_pkg::reg_addr_t reg_addr,
    output io_pkg::word_t     reg_wdata,
    input  io_pkg::word_t     reg_rdata
);

    io_pkg::rd_state_t rd_state;
    io_pkg::wr_state_t wr_state;
    io_pkg::reg_addr_t ar_addr_q;
    logic              rd_pend;
    logic              wr_prio;
    logic              wr_req;
    logic              rd_req;
    logic              wr_go;
    logic              rd_go;

    // the register port is busy during the read access cycle, so writes wait
    assign wr_req = awvalid && wvalid && (wr_state == io_pkg::wr_idle)
                    && (rd_state != io_pkg::rd_access);
    assign rd_req = arvalid && (rd_state == io_pkg::rd_idle);

    // round robin between a write pair and a read when both wait
    assign wr_go = wr_req && (wr_prio || !rd_req);
    assign rd_go = rd_req && (!wr_prio || !wr_req);

    assign awready = wr_go;
    assign wready = wr_go;
    assign arready = rd_go;

    assign reg_wr_en = wr_go;
    assign reg_rd_en = (rd_state == io_pkg::rd_access);
    assign reg_addr = reg_rd_en ? ar_addr_q : awaddr[7:0];
    assign reg_wdata = wdata;

    assign bvalid = (wr_state == io_pkg::wr_respond);
    assign bresp = io_pkg::resp_okay;
    assign rresp = io_pkg::resp_okay;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= io_pkg::wr_idle;
            wr_prio <= 1'b1;
        end else begin
            if (wr_go) begin
                wr_state <= io_pkg::wr_respond;
                wr_prio <= 1'b0;
            end else if (bvalid && bready) begin
                wr_state <= io_pkg::wr_idle;
            end
            if (rd_go) begin
                wr_prio <= 1'b1;
            end
        end
    end

    // **************************************************
    // read channel
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= io_pkg::rd_idle;
            rd_pend <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            rd_pend <= reg_rd_en;
            case (rd_state)
                io_pkg::rd_idle: begin
                    if (rd_go) begin
                        rd_state <= io_pkg::rd_access;
                    end
                end
                io_pkg::rd_access: begin
                    rd_state <= io_pkg::rd_respond;
                end
                io_pkg::rd_respond: begin
                    // register data arrives one cycle after the access
                    if (rd_pend) begin
                        rvalid <= 1'b1;
                    end else if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        rd_state <= io_pkg::rd_idle;
                    end
                end
                default: rd_state <= io_pkg::rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            ar_addr_q <= araddr[7:0];
        end
        if (rd_pend) begin
            rdata <= reg_rdata;
        end
    end

endmodule

//--- logic/io_params.svh
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// **************************************************
// clocking and line rate
// **************************************************

`define IO_CLOCK_FREQ 125_000_000
`define IO_BAUD_RATE 115_200

// default bit period in clock cycles
`define IO_CLKS_PER_BIT (`IO_CLOCK_FREQ / `IO_BAUD_RATE)

// **************************************************
// register map, byte offsets within the block
// **************************************************

`define IO_ADDR_UART_CTRL 8'h00
`define IO_ADDR_UART_RDATA 8'h04
`define IO_ADDR_UART_TDATA 8'h08
`define IO_ADDR_CYCLE_CNT 8'h0c
`define IO_ADDR_INST_CNT 8'h10
`define IO_ADDR_RST_CNT 8'h14
`define IO_ADDR_BR_INST_CNT 8'h18
`define IO_ADDR_BR_SUC_CNT 8'h1c

// addi x0, x0, 0 is what the pipeline inserts for a bubble
`define IO_NOP 32'h0000_0013

`endif

//--- logic/io_pkg.sv
package io_pkg;

    // **************************************************
    // bus and register types
    // **************************************************

    typedef logic [31:0] word_t;
    typedef logic [7:0] reg_addr_t;

    // counter widths as seen by software, zero-extended on read
    typedef logic [27:0] cycle_cnt_t;
    typedef logic [23:0] event_cnt_t;

    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay = 2'b00;

    // **************************************************
    // channel state machines of the bus slave
    // **************************************************

    typedef enum logic [1:0] {
        rd_idle,
        rd_access,
        rd_respond
    } rd_state_t;

    typedef enum logic {
        wr_idle,
        wr_respond
    } wr_state_t;

endpackage

//--- logic/io_regs.sv
`timescale 1ns/1ps

`include "io_params.svh"

module io_regs (
    input  logic              clk,
    input  logic              rst,

    input  logic              reg_rd_en,
    input  logic              reg_wr_en,
    input  io_pkg::reg_addr_t reg_addr,
    input  io_pkg::word_t     reg_wdata,
    output io_pkg::word_t     reg_rdata,

    input  io_pkg::word_t     inst,
    input  io_pkg::word_t     fp_inst,
    input  logic              br_inst,
    input  logic              br_suc,

    output uart_pkg::byte_t   tx_data,
    output logic              tx_valid,
    input  logic              tx_ready,

    input  uart_pkg::byte_t   rx_data,
    input  logic              rx_valid,
    output logic              rx_ready
);

    io_pkg::cycle_cnt_t cycle_cnt;
    io_pkg::event_cnt_t inst_cnt;
    io_pkg::event_cnt_t br_inst_cnt;
    io_pkg::event_cnt_t br_suc_cnt;
    logic [1:0]         inst_inc;
    logic               cnt_clr;
    logic               tdata_wr;
    logic               rdata_rd;
    logic               rx_full;
    uart_pkg::byte_t    rx_buf;

    // both issue slots can retire in the same cycle
    assign inst_inc = {1'b0, inst != `IO_NOP} + {1'b0, fp_inst != `IO_NOP};

    assign cnt_clr = reg_wr_en && (reg_addr == `IO_ADDR_RST_CNT);
    assign tdata_wr = reg_wr_en && (reg_addr == `IO_ADDR_UART_TDATA);
    assign rdata_rd = reg_rd_en && (reg_addr == `IO_ADDR_UART_RDATA);

    assign rx_ready = !rx_full;

    // **************************************************
    // performance counters
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst || cnt_clr) begin
            cycle_cnt <= '0;
            inst_cnt <= '0;
            br_inst_cnt <= '0;
            br_suc_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            inst_cnt <= inst_cnt + io_pkg::event_cnt_t'(inst_inc);
            br_inst_cnt <= br_inst_cnt + io_pkg::event_cnt_t'(br_inst);
            br_suc_cnt <= br_suc_cnt + io_pkg::event_cnt_t'(br_suc);
        end
    end

    // **************************************************
    // uart buffers
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            rx_full <= 1'b0;
        end else begin
            // a new write keeps the handoff pending even if the old byte leaves now
            if (tdata_wr) begin
                tx_valid <= 1'b1;
            end else if (tx_valid && tx_ready) begin
                tx_valid <= 1'b0;
            end
            if (rx_valid && rx_ready) begin
                rx_full <= 1'b1;
            end else if (rdata_rd) begin
                rx_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tdata_wr) begin
            tx_data <= reg_wdata[7:0];
        end
        if (rx_valid && rx_ready) begin
            rx_buf <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            case (reg_addr)
                `IO_ADDR_UART_CTRL:   reg_rdata <= {30'b0, rx_full, tx_ready};
                `IO_ADDR_UART_RDATA:  reg_rdata <= {24'b0, rx_buf};
                `IO_ADDR_CYCLE_CNT:   reg_rdata <= io_pkg::word_t'(cycle_cnt);
                `IO_ADDR_INST_CNT:    reg_rdata <= io_pkg::word_t'(inst_cnt);
                `IO_ADDR_BR_INST_CNT: reg_rdata <= io_pkg::word_t'(br_inst_cnt);
                `IO_ADDR_BR_SUC_CNT:  reg_rdata <= io_pkg::word_t'(br_suc_cnt);
                default:              reg_rdata <= '0;
            endcase
        end
    end

endmodule

//--- logic/io_top.sv
`timescale 1ns/1ps

`include "io_params.svh"

module io_top #(
    parameter int unsigned clks_per_bit = `IO_CLKS_PER_BIT
) (
    input  logic          clk,
    input  logic          rst,

    input  io_pkg::word_t awaddr,
    input  logic          awvalid,
    output logic          awready,
    input  io_pkg::word_t wdata,
    input  logic          wvalid,
    output logic          wready,
    output io_pkg::resp_t bresp,
    output logic          bvalid,
    input  logic          bready,
    input  io_pkg::word_t araddr,
    input  logic          arvalid,
    output logic          arready,
    output io_pkg::word_t rdata,
    output io_pkg::resp_t rresp,
    output logic          rvalid,
    input  logic          rready,

    input  io_pkg::word_t inst,
    input  io_pkg::word_t fp_inst,
    input  logic          br_inst,
    input  logic          br_suc,

    input  logic          serial_in,
    output logic          serial_out
);

    logic              reg_rd_en;
    logic              reg_wr_en;
    io_pkg::reg_addr_t reg_addr;
    io_pkg::word_t     reg_wdata;
    io_pkg::word_t     reg_rdata;
    uart_pkg::byte_t   tx_data;
    logic              tx_valid;
    logic              tx_ready;
    uart_pkg::byte_t   rx_data;
    logic              rx_valid;
    logic              rx_ready;

    axil_io_slave axil_io_slave_inst (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .reg_rd_en (reg_rd_en),
        .reg_wr_en (reg_wr_en),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata)
    );

    io_regs io_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .reg_rd_en (reg_rd_en),
        .reg_wr_en (reg_wr_en),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .inst      (inst),
        .fp_inst   (fp_inst),
        .br_inst   (br_inst),
        .br_suc    (br_suc),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_inst (
        .clk        (clk),
        .rst        (rst),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) uart_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready)
    );

endmodule

//--- logic/uart_pkg.sv
package uart_pkg;

    typedef logic [7:0] byte_t;

    // one start bit, eight data bits and one stop bit per frame
    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } rx_state_t;

endpackage

//--- logic/uart_rx.sv
`timescale 1ns/1ps

`include "io_params.svh"

module uart_rx #(
    parameter int unsigned clks_per_bit = `IO_CLKS_PER_BIT
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            serial_in,
    output uart_pkg::byte_t rx_data,
    output logic            rx_valid,
    input  logic            rx_ready
);

    localparam int unsigned cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] baud_last = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] baud_mid = cnt_w'((clks_per_bit - 1) / 2);

    uart_pkg::rx_state_t state;
    uart_pkg::byte_t     shift;
    logic [2:0]          sync;
    logic [cnt_w-1:0]    baud_cnt;
    logic [2:0]          bit_idx;
    logic                rx_bit;
    logic                fall;

    // two flops for metastability and a third one for edge detection
    assign rx_bit = sync[1];
    assign fall = sync[2] && !sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 3'b111;
            state <= uart_pkg::rx_st_idle;
            baud_cnt <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync <= {sync[1:0], serial_in};
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            case (state)
                uart_pkg::rx_st_idle: begin
                    baud_cnt <= '0;
                    if (fall) begin
                        state <= uart_pkg::rx_st_start;
                    end
                end
                uart_pkg::rx_st_start: begin
                    // from the middle of the start bit every sample is a full period apart
                    if (baud_cnt == baud_mid) begin
                        baud_cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_bit ? uart_pkg::rx_st_idle : uart_pkg::rx_st_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_st_data: begin
                    if (baud_cnt == baud_last) begin
                        baud_cnt <= '0;
                        shift <= {rx_bit, shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::rx_st_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (baud_cnt == baud_last) begin
                        baud_cnt <= '0;
                        state <= uart_pkg::rx_st_idle;
                        // the byte is dropped on a framing error or when still unclaimed
                        if (rx_bit && (!rx_valid || rx_ready)) begin
                            rx_data <= shift;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int unsigned clks_per_bit
) (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t tx_data,
    input  logic            tx_valid,
    output logic            tx_ready,
    output logic            serial_out
);

    localparam int unsigned cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] baud_last = cnt_w'(clks_per_bit - 1);

    uart_pkg::tx_state_t state;
    uart_pkg::byte_t     shift;
    logic [cnt_w-1:0]    baud_cnt;
    logic [2:0]          bit_idx;
    logic                baud_done;

    assign baud_done = (baud_cnt == baud_last);
    assign tx_ready = (state == uart_pkg::tx_st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= uart_pkg::tx_st_idle;
            baud_cnt <= '0;
            bit_idx <= '0;
            serial_out <= 1'b1;
        end else if (state == uart_pkg::tx_st_idle) begin
            baud_cnt <= '0;
            if (tx_valid) begin
                shift <= tx_data;
                serial_out <= 1'b0;
                state <= uart_pkg::tx_st_start;
            end
        end else if (!baud_done) begin
            baud_cnt <= baud_cnt + 1'b1;
        end else begin
            baud_cnt <= '0;
            case (state)
                uart_pkg::tx_st_start: begin
                    bit_idx <= '0;
                    serial_out <= shift[0];
                    shift <= shift >> 1;
                    state <= uart_pkg::tx_st_data;
                end
                uart_pkg::tx_st_data: begin
                    if (bit_idx == 3'd7) begin
                        serial_out <= 1'b1;
                        state <= uart_pkg::tx_st_stop;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        serial_out <= shift[0];
                        shift <= shift >> 1;
                    end
                end
                default: state <= uart_pkg::tx_st_idle;
            endcase
        end
    end

endmodule

//--- src.f
+incdir+logic
logic/io_pkg.sv
logic/uart_pkg.sv
logic/axil_io_slave.sv
logic/io_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/io_top.sv
bench/io_chk.sv
bench/io_tb.sv
